// File: spi_rx_top.f
spi_pkg.sv
spi_frame_rx.sv
async_fifo.sv
spi_rx_top.sv
spi_rx_top_sva.sv
tb_spi_rx_top.sv

// File: Bender.yml
package:
  name: spi_rx

sources:
  - spi_pkg.sv
  - spi_frame_rx.sv
  - async_fifo.sv
  - spi_rx_top.sv
  - target: test
    files:
      - spi_rx_top_sva.sv
      - tb_spi_rx_top.sv

// File: tb_spi_rx_top.sv
module tb_spi_rx_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TESTS       = 6;
    localparam int SETTLE_CYCLES = 60; // drain and hold time allowed per test.

    logic                clk_spi;
    logic                clk_sys;
    logic                rstb;
    logic                cs;
    logic                spi_mosi;
    logic                rd_en_opcode;
    logic                rd_en_data;
    spi_pkg::opcode_t    fifo_opcode;
    spi_pkg::data_word_t fifo_data;
    logic                empty_opcode;
    logic                empty_data;
    logic                full_opcode;
    logic                full_data;

    spi_pkg::opcode_t    exp_opcode[$]; // words still owed by the DUT in arrival order.
    spi_pkg::data_word_t exp_data[$];
    int                  plan_words[$];
    int                  plan_partial[$];
    int                  plan_idle[$];
    int                  frames_per_test[N_TESTS+1];
    int unsigned         planned_cycles = 0;
    int unsigned         cycle_limit = 0;
    int unsigned         cycle_cnt = 0;
    int                  err_cnt = 0;
    int                  err_mark = 0;
    int                  check_cnt = 0;
    int                  tests_done = 0;
    int                  stall_opcode = 0;
    int                  stall_data = 0;
    logic                stalled = 1'b0; // reader held off while the buffers fill.
    logic                read_allow = 1'b0;
    logic                read_hold = 1'b0;

    spi_rx_top DUT (.*);

    initial begin
        clk_spi = 1'b0;
        forever #5 clk_spi = ~clk_spi;
    end

    initial begin
        clk_sys = 1'b0;
        forever #3 clk_sys = ~clk_sys;
    end

    always @(posedge clk_spi) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not end within %0d clk_spi cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // frame planning and generation
    ////////////////////////////////////////////////////////////

    task automatic plan_frame(input int test, input int words, input int partial);
        int idle;
        idle = $urandom_range(6, 2);
        plan_words.push_back(words);
        plan_partial.push_back(partial);
        plan_idle.push_back(idle);
        frames_per_test[test]++;
        planned_cycles += spi_pkg::OPCODE_BITS + words * spi_pkg::DATA_BITS + partial + 1 + idle;
    endtask

    task automatic make_plan();
        for (int i = 0; i < 6; i++)
            plan_frame(2, $urandom_range(2, 0), 0);
        for (int i = 0; i < 8; i++)
            plan_frame(3, $urandom_range(5, 0), 0);
        for (int i = 0; i < 8; i++)
            plan_frame(4, $urandom_range(5, 0), (i % 2 == 1) ? $urandom_range(15, 1) : 0);
        plan_frame(5, 20, 0); // more words than the data FIFO holds.
        for (int i = 0; i < 5; i++)
            plan_frame(5, 0, 0);
        plan_frame(6, 2, 0);
        planned_cycles += N_TESTS * SETTLE_CYCLES + 4;
        cycle_limit = 2 * planned_cycles;
    endtask

    task automatic send_word(input logic [15:0] value, input int nbits);
        for (int b = nbits - 1; b >= 0; b--) begin
            @(negedge clk_spi);
            cs       = 1'b0;
            spi_mosi = value[b];
        end
    endtask

    // a completed word is kept unless the model knows its FIFO is already full.
    task automatic note_opcode(input spi_pkg::opcode_t op);
        logic exp_full;
        exp_full = stalled && (stall_opcode >= spi_pkg::OPCODE_FIFO_DEPTH);
        compare_value("full_opcode", full_opcode, exp_full);
        if (!exp_full) begin
            exp_opcode.push_back(op);
            stall_opcode += stalled;
        end
    endtask

    task automatic note_data(input spi_pkg::data_word_t w);
        logic exp_full;
        exp_full = stalled && (stall_data >= spi_pkg::DATA_FIFO_DEPTH);
        compare_value("full_data", full_data, exp_full);
        if (!exp_full) begin
            exp_data.push_back(w);
            stall_data += stalled;
        end
    endtask

    task automatic send_frame();
        int                  words;
        int                  partial;
        int                  idle;
        spi_pkg::opcode_t    op;
        spi_pkg::data_word_t w;
        words   = plan_words.pop_front();
        partial = plan_partial.pop_front();
        idle    = plan_idle.pop_front();
        op      = spi_pkg::opcode_t'($urandom);
        send_word(op, spi_pkg::OPCODE_BITS);
        note_opcode(op);
        for (int i = 0; i < words; i++) begin
            w = spi_pkg::data_word_t'($urandom);
            send_word(w, spi_pkg::DATA_BITS);
            note_data(w);
        end
        if (partial > 0) begin
            w = spi_pkg::data_word_t'($urandom);
            send_word(w, partial); // never completes, so the model keeps nothing.
        end
        @(negedge clk_spi);
        cs       = 1'b1;
        spi_mosi = 1'b0;
        repeat (idle) @(negedge clk_spi);
    endtask

    task automatic run_frames(input int n);
        repeat (n) send_frame();
    endtask

    task automatic wait_drain();
        while (exp_opcode.size() != 0 || exp_data.size() != 0)
            @(negedge clk_spi);
        repeat (8) @(negedge clk_spi);
        compare_value("empty_opcode", empty_opcode, 1'b1);
        compare_value("empty_data", empty_data, 1'b1);
    endtask

    task automatic finish_test(input int t, input string name);
        $display("test %0d (%s) finished with %0d errors", t, name, err_cnt - err_mark);
        err_mark = err_cnt;
        tests_done++;
    endtask

    ////////////////////////////////////////////////////////////
    // system side reader
    ////////////////////////////////////////////////////////////

    task automatic service_opcode();
        logic want;
        want = read_hold || (read_allow && $urandom_range(1, 0) == 1);
        rd_en_opcode = want;
        if (want && !empty_opcode) begin
            if (exp_opcode.size() == 0) begin
                $display("error at %0t ns: fifo_opcode shows an opcode that was never sent", $time);
                err_cnt++;
            end else begin
                compare_value("fifo_opcode", fifo_opcode, exp_opcode.pop_front());
            end
        end
    endtask

    task automatic service_data();
        logic want;
        want = read_hold || (read_allow && $urandom_range(1, 0) == 1);
        rd_en_data = want;
        if (want && !empty_data) begin
            if (exp_data.size() == 0) begin
                $display("error at %0t ns: fifo_data shows a word that was never sent", $time);
                err_cnt++;
            end else begin
                compare_value("fifo_data", fifo_data, exp_data.pop_front());
            end
        end
    endtask

    task automatic read_loop();
        forever begin
            @(negedge clk_sys);
            service_opcode();
            service_data();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int total_err;
        void'($urandom(79));
        cs           = 1'b1;
        spi_mosi     = 1'b0;
        rstb         = 1'b0;
        rd_en_opcode = 1'b0;
        rd_en_data   = 1'b0;
        make_plan();
        fork
            read_loop();
        join_none
        repeat (3) @(posedge clk_spi);
        @(negedge clk_spi);
        rstb = 1'b1;

        compare_value("empty_opcode", empty_opcode, 1'b1);
        compare_value("empty_data", empty_data, 1'b1);
        compare_value("full_opcode", full_opcode, 1'b0);
        compare_value("full_data", full_data, 1'b0);
        finish_test(1, "reset state");

        read_allow = 1'b1;
        run_frames(frames_per_test[2]);
        wait_drain();
        finish_test(2, "opcode order");
        run_frames(frames_per_test[3]);
        wait_drain();
        finish_test(3, "data order");
        run_frames(frames_per_test[4]);
        wait_drain();
        finish_test(4, "cut frames");

        read_allow = 1'b0;
        stalled    = 1'b1;
        run_frames(1);
        compare_value("full_data", full_data, 1'b1);
        stalled    = 1'b0;
        read_allow = 1'b1;
        wait_drain();
        read_allow   = 1'b0;
        stalled      = 1'b1;
        stall_opcode = 0;
        run_frames(5);
        compare_value("full_opcode", full_opcode, 1'b1);
        stalled    = 1'b0;
        read_allow = 1'b1;
        wait_drain();
        finish_test(5, "overflow");

        read_allow = 1'b0;
        read_hold  = 1'b1; // rd_en stays high on both empty FIFOs.
        repeat (12) @(negedge clk_sys);
        compare_value("empty_opcode", empty_opcode, 1'b1);
        compare_value("empty_data", empty_data, 1'b1);
        run_frames(frames_per_test[6]);
        wait_drain();
        read_hold = 1'b0;
        finish_test(6, "pop while empty");

        total_err = err_cnt + DUT.u_opcode_fifo.u_sva.sva_errors
                  + DUT.u_data_fifo.u_sva.sva_errors;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_done,
                 check_cnt, err_cnt, total_err - err_cnt);
        if (total_err == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: spi_rx_top_sva.sv
module spi_rx_top_sva #(
    parameter int ADDR_W = 2
) (
    input logic            wr_clk,
    input logic            rd_clk,
    input logic            rstb,
    input logic            wr_en,
    input logic            rd_en,
    input logic            full,
    input logic            empty,
    input logic [ADDR_W:0] wr_bin,
    input logic [ADDR_W:0] rd_bin
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned sva_errors = 0;

    property p_wr_hold_when_full;
        @(posedge wr_clk) disable iff (!rstb)
        (wr_en && full) |=> $stable(wr_bin);
    endproperty

    property p_rd_hold_when_empty;
        @(posedge rd_clk) disable iff (!rstb)
        (rd_en && empty) |=> $stable(rd_bin);
    endproperty

    // the first read clock after reset release must see an empty buffer.
    property p_empty_after_reset;
        @(posedge rd_clk) $rose(rstb) |-> empty;
    endproperty

    a_wr_hold_when_full: assert property (p_wr_hold_when_full) else begin
        $error("write pointer moved on a write into a full FIFO");
        sva_errors++;
    end

    a_rd_hold_when_empty: assert property (p_rd_hold_when_empty) else begin
        $error("read pointer moved on a pop from an empty FIFO");
        sva_errors++;
    end

    a_empty_after_reset: assert property (p_empty_after_reset) else begin
        $error("FIFO not empty in the first read cycle after reset");
        sva_errors++;
    end

endmodule

bind async_fifo spi_rx_top_sva #(.ADDR_W(ADDR_W)) u_sva (
    .wr_clk (wr_clk),
    .rd_clk (rd_clk),
    .rstb   (rstb),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .full   (full),
    .empty  (empty),
    .wr_bin (wr_bin),
    .rd_bin (rd_bin)
);

// File: spi_rx_top.sv
module spi_rx_top (
    input  logic                clk_spi,
    input  logic                clk_sys,
    input  logic                rstb,

    input  logic                cs,
    input  logic                spi_mosi,

    input  logic                rd_en_opcode,
    input  logic                rd_en_data,

    output spi_pkg::opcode_t    fifo_opcode,
    output spi_pkg::data_word_t fifo_data,
    output logic                empty_opcode,
    output logic                empty_data,

    output logic                full_opcode,
    output logic                full_data
);

    logic                wr_en_opcode;
    logic                wr_en_data;
    spi_pkg::opcode_t    opcode;
    spi_pkg::data_word_t data_word;

    spi_frame_rx u_frame_rx (
        .clk_spi      (clk_spi),
        .rstb         (rstb),
        .cs           (cs),
        .spi_mosi     (spi_mosi),
        .wr_en_opcode (wr_en_opcode),
        .opcode       (opcode),
        .wr_en_data   (wr_en_data),
        .data_word    (data_word)
    );

    ////////////////////////////////////////////////////////////
    // crossings into the system clock
    ////////////////////////////////////////////////////////////

    async_fifo #(
        .payload_t (spi_pkg::opcode_t),
        .DEPTH     (spi_pkg::OPCODE_FIFO_DEPTH)
    ) u_opcode_fifo (
        .wr_clk (clk_spi),
        .wr_en  (wr_en_opcode),
        .din    (opcode),
        .full   (full_opcode),
        .rd_clk (clk_sys),
        .rd_en  (rd_en_opcode),
        .dout   (fifo_opcode),
        .empty  (empty_opcode),
        .rstb   (rstb)
    );

    async_fifo #(
        .payload_t (spi_pkg::data_word_t),
        .DEPTH     (spi_pkg::DATA_FIFO_DEPTH)
    ) u_data_fifo (
        .wr_clk (clk_spi),
        .wr_en  (wr_en_data),
        .din    (data_word),
        .full   (full_data),
        .rd_clk (clk_sys),
        .rd_en  (rd_en_data),
        .dout   (fifo_data),
        .empty  (empty_data),
        .rstb   (rstb)
    );

endmodule

// File: async_fifo.sv
module async_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     wr_clk,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_clk,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty,
    input  logic     rstb
);

    localparam int ADDR_W = $clog2(DEPTH);

    // one extra bit tells a full buffer from an empty one.
    typedef logic [ADDR_W:0] ptr_t;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    payload_t mem [DEPTH];

    ptr_t wr_bin;
    ptr_t wr_bin_next;
    ptr_t wr_gray;
    ptr_t wr_gray_next;
    ptr_t rd_gray_sync1;
    ptr_t rd_gray_sync2;
    logic wr_inc;

    ptr_t rd_bin;
    ptr_t rd_bin_next;
    ptr_t rd_gray;
    ptr_t rd_gray_next;
    ptr_t wr_gray_sync1;
    ptr_t wr_gray_sync2;
    logic rd_inc;

    ////////////////////////////////////////////////////////////
    // write domain
    ////////////////////////////////////////////////////////////

    assign wr_inc       = wr_en && !full; // a write into a full buffer is lost.
    assign wr_bin_next  = wr_bin + ptr_t'(wr_inc);
    assign wr_gray_next = bin2gray(wr_bin_next);

    always_ff @(posedge wr_clk) begin
        if (wr_inc) begin
            mem[wr_bin[ADDR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge wr_clk or negedge rstb) begin
        if (!rstb) begin
            wr_bin        <= '0;
            wr_gray       <= '0;
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
            full          <= 1'b0;
        end else begin
            wr_bin        <= wr_bin_next;
            wr_gray       <= wr_gray_next;
            rd_gray_sync1 <= rd_gray;
            rd_gray_sync2 <= rd_gray_sync1;
            // full when the top two gray bits differ and the rest match.
            full          <= (wr_gray_next == {~rd_gray_sync2[ADDR_W -: 2],
                                               rd_gray_sync2[ADDR_W-2:0]});
        end
    end

    ////////////////////////////////////////////////////////////
    // read domain
    ////////////////////////////////////////////////////////////

    assign rd_inc       = rd_en && !empty; // popping an empty buffer does nothing.
    assign rd_bin_next  = rd_bin + ptr_t'(rd_inc);
    assign rd_gray_next = bin2gray(rd_bin_next);

    assign dout = mem[rd_bin[ADDR_W-1:0]]; // head is visible while not empty.

    always_ff @(posedge rd_clk or negedge rstb) begin
        if (!rstb) begin
            rd_bin        <= '0;
            rd_gray       <= '0;
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
            empty         <= 1'b1;
        end else begin
            rd_bin        <= rd_bin_next;
            rd_gray       <= rd_gray_next;
            wr_gray_sync1 <= wr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
            empty         <= (rd_gray_next == wr_gray_sync2);
        end
    end

endmodule

// File: spi_frame_rx.sv
module spi_frame_rx (
    input  logic                clk_spi,
    input  logic                rstb,
    input  logic                cs,
    input  logic                spi_mosi,
    output logic                wr_en_opcode,
    output spi_pkg::opcode_t    opcode,
    output logic                wr_en_data,
    output spi_pkg::data_word_t data_word
);

    typedef enum logic {
        PH_OPCODE,
        PH_DATA
    } phase_t;

    // wide enough to count the bits of the longest word.
    typedef logic [$clog2(spi_pkg::DATA_BITS)-1:0] cnt_t;

    phase_t              phase;
    cnt_t                bit_cnt;
    spi_pkg::data_word_t shift_reg;
    spi_pkg::data_word_t shift_next;
    logic                opcode_done;
    logic                data_done;

    assign shift_next = {shift_reg[spi_pkg::DATA_BITS-2:0], spi_mosi}; // msb comes first.

    assign opcode_done = !cs && (phase == PH_OPCODE) &&
                         (bit_cnt == cnt_t'(spi_pkg::OPCODE_BITS - 1));

    assign data_done   = !cs && (phase == PH_DATA) &&
                         (bit_cnt == cnt_t'(spi_pkg::DATA_BITS - 1));

    ////////////////////////////////////////////////////////////
    // phase and bit counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_spi or negedge rstb) begin
        if (!rstb) begin
            phase        <= PH_OPCODE;
            bit_cnt      <= '0;
            wr_en_opcode <= 1'b0;
            wr_en_data   <= 1'b0;
        end else begin
            wr_en_opcode <= opcode_done; // strobe lands in the cycle after the last bit.
            wr_en_data   <= data_done;
            if (cs) begin
                phase   <= PH_OPCODE; // a partial word is simply forgotten.
                bit_cnt <= '0;
            end else begin
                case (phase)
                    PH_OPCODE: begin
                        if (opcode_done) begin
                            phase   <= PH_DATA;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    PH_DATA: begin
                        if (data_done) begin
                            bit_cnt <= '0; // stay in the data phase until cs rises.
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: begin
                        phase   <= PH_OPCODE;
                        bit_cnt <= '0;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shift register and word outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_spi) begin
        if (!cs) begin
            shift_reg <= shift_next;
        end
        if (opcode_done) begin
            opcode <= shift_next[spi_pkg::OPCODE_BITS-1:0]; // held until the next opcode.
        end
        if (data_done) begin
            data_word <= shift_next;
        end
    end

endmodule

// File: spi_pkg.sv
package spi_pkg;

    ////////////////////////////////////////////////////////////
    // payload types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  opcode_t;    // one opcode, sent first in a frame.
    typedef logic [15:0] data_word_t; // one data word of the bulk phase.

    ////////////////////////////////////////////////////////////
    // frame format
    ////////////////////////////////////////////////////////////

    localparam int OPCODE_BITS = 8;
    localparam int DATA_BITS   = 16;

    ////////////////////////////////////////////////////////////
    // clock crossing buffers
    ////////////////////////////////////////////////////////////

    // both depths have to be powers of two for the gray pointers.
    localparam int OPCODE_FIFO_DEPTH = 4;
    localparam int DATA_FIFO_DEPTH   = 16;

endpackage
